// File: vlog.f
+incdir+.
lockstep_pkg.sv
acc_core.sv
lockstep_rst_seq.sv
lockstep_delay.sv
lockstep_compare.sv
core_lockstep.sv
tb_core_lockstep.sv

// File: Bender.yml
package:
  name: core_lockstep

sources:
  - lockstep_pkg.sv
  - acc_core.sv
  - lockstep_rst_seq.sv
  - lockstep_delay.sv
  - lockstep_compare.sv
  - core_lockstep.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_core_lockstep.sv

// File: tb_lockstep_tasks.svh
////////////////////////////////////////////////////////////
// Lockstep testbench tasks
// Command driver, value checks and the directed tests,
// included into the testbench module
////////////////////////////////////////////////////////////

task automatic check_bit(input string name, input logic exp, input logic act);
  if (exp !== act) begin
    fail_run($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
  end
endtask

task automatic check_data(input string name,
                          input logic [lockstep_pkg::DataWidth-1:0] exp,
                          input logic [lockstep_pkg::DataWidth-1:0] act);
  if (exp !== act) begin
    fail_run($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
  end
endtask

task automatic check_alerts(input logic exp_int, input logic exp_minor, input logic exp_bus);
  check_bit("alert_major_internal_o", exp_int, alert_major_internal);
  check_bit("alert_minor_o", exp_minor, alert_minor);
  check_bit("alert_major_bus_o", exp_bus, alert_major_bus);
endtask

// Caller sits on the negedge for step k0 and expects a pulse at step PulseAt
task automatic pulse_window(input int unsigned k0, input logic int_hit,
                            input logic minor_hit, input logic bus_hit);
  for (int unsigned k = k0; k < PulseAt + 3; k++) begin
    if (k > k0) begin
      @(negedge clk_i);
    end
    check_alerts(int_hit && (k == PulseAt), minor_hit && (k == PulseAt),
                 bus_hit && (k == PulseAt));
  end
endtask

// Even parity over word and parity bit unless bad_par flips it
task automatic start_cmd(input lockstep_pkg::opcode_e op,
                         input logic [lockstep_pkg::ImmWidth-1:0] field, input logic bad_par);
  lockstep_pkg::cmd_word_u word;
  word.imm.op  = op;
  word.imm.imm = field;
  @(posedge clk_i);
  cmd_word  <= word;
  cmd_par   <= (^word) ^ bad_par;
  cmd_req   <= 1'b1;
  ack_delay <= $urandom % 4;
endtask

task automatic finish_cmd();
  while (!m_cmd_ack) begin
    @(negedge clk_i);
  end
  @(posedge clk_i);
  cmd_req <= 1'b0;
  do begin
    @(negedge clk_i);
  end while (m_cmd_ack);
endtask

// Good-parity command with the reference accumulator following it
task automatic run_cmd(input lockstep_pkg::opcode_e op,
                       input logic [lockstep_pkg::ImmWidth-1:0] field);
  start_cmd(op, field, 1'b0);
  finish_cmd();
  case (op)
    lockstep_pkg::OpAdd:   exp_acc = exp_acc + field;
    lockstep_pkg::OpXor:   exp_acc = exp_acc ^ field;
    lockstep_pkg::OpLoad:  exp_acc = exp_acc + fill_word(field);
    lockstep_pkg::OpStore: check_data("bus_wdata", exp_acc, wr_data);
    default: ;
  endcase
endtask

////////////////////////////////////////////////////////////
// Directed tests
////////////////////////////////////////////////////////////

// Main outputs are corrupted all through reset while compare is off
task automatic quiet_through_reset();
  repeat (2) @(posedge clk_i);
  mon_en = 1'b1;
  repeat (14) @(posedge clk_i);
  rst_ni       <= 1'b1;
  corrupt_mask <= '0;
  repeat (8) @(posedge clk_i);
endtask

task automatic good_command_sequence();
  run_cmd(lockstep_pkg::OpAdd, 12'h3a7);
  run_cmd(lockstep_pkg::OpXor, 12'h5c3);
  run_cmd(lockstep_pkg::OpStore, 12'h100);
  run_cmd(lockstep_pkg::OpLoad, 12'h2f0);
  run_cmd(lockstep_pkg::OpStore, 12'h104);
endtask

task automatic corrupted_store();
  start_cmd(lockstep_pkg::OpStore, 12'h010, 1'b0);
  window_open = 1'b1;
  do begin
    @(negedge clk_i);
    check_alerts(1'b0, 1'b0, 1'b0);
  end while (!m_bus_req);
  // One-cycle flip of a single write data bit
  @(posedge clk_i);
  corrupt_mask <= 16'h0040;
  @(negedge clk_i);
  check_alerts(1'b0, 1'b0, 1'b0);
  @(posedge clk_i);
  corrupt_mask <= '0;
  @(negedge clk_i);
  pulse_window(1, 1'b1, 1'b0, 1'b0);
  finish_cmd();
  check_data("bus_wdata", exp_acc, wr_data);
  @(posedge clk_i);
  window_open = 1'b0;
endtask

task automatic bad_parity_command();
  start_cmd(lockstep_pkg::OpAdd, 12'h0ff, 1'b1);
  window_open = 1'b1;
  @(negedge clk_i);
  pulse_window(0, 1'b0, 1'b1, 1'b0);
  finish_cmd();
  @(posedge clk_i);
  window_open = 1'b0;
  run_cmd(lockstep_pkg::OpStore, 12'h020);
endtask

task automatic load_with_bus_error();
  start_cmd(lockstep_pkg::OpLoad, 12'h0a4, 1'b0);
  window_open = 1'b1;
  err_next    = 1'b1;
  do begin
    @(negedge clk_i);
    if (!bus_ack) begin
      check_alerts(1'b0, 1'b0, 1'b0);
    end
  end while (!bus_ack);
  pulse_window(0, 1'b0, 1'b0, 1'b1);
  err_next = 1'b0;
  finish_cmd();
  @(posedge clk_i);
  window_open = 1'b0;
  run_cmd(lockstep_pkg::OpStore, 12'h024);
endtask

// File: tb_core_lockstep.sv
////////////////////////////////////////////////////////////
// Lockstep checker testbench
// Runs a main accumulator core beside the checker, with a
// handshake memory model and a bit-flip path on the main
// core's write data into the DUT
////////////////////////////////////////////////////////////

module tb_core_lockstep;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned LockstepOffset = 2;
  // Edges from a cause to the alert it raises at the DUT
  localparam int unsigned PulseAt        = LockstepOffset + 1;
  localparam int unsigned TimeoutCycles  = 4000;
  localparam logic [31:0] Seed           = 32'h0bbae8df;

  logic                               clk_i;
  logic                               rst_ni;
  logic                               cmd_req;
  lockstep_pkg::cmd_word_u            cmd_word;
  logic                               cmd_par;
  logic                               bus_ack;
  logic [lockstep_pkg::DataWidth-1:0] bus_rdata;
  logic                               bus_err;

  logic                               m_cmd_ack;
  logic                               m_bus_req;
  logic                               m_bus_we;
  logic [lockstep_pkg::AddrWidth-1:0] m_bus_addr;
  logic [lockstep_pkg::DataWidth-1:0] m_bus_wdata;
  logic [lockstep_pkg::DataWidth-1:0] m_acc;
  logic [lockstep_pkg::DataWidth-1:0] corrupt_mask;

  logic                               alert_minor;
  logic                               alert_major_internal;
  logic                               alert_major_bus;

  int unsigned                        ack_delay;
  int unsigned                        wait_cnt;
  logic                               err_next;
  logic [lockstep_pkg::DataWidth-1:0] wr_data;
  logic [lockstep_pkg::DataWidth-1:0] exp_acc;
  logic                               mon_en;
  logic                               window_open;
  int unsigned                        cycle_cnt;

  always #10 clk_i = ~clk_i;

  acc_core u_main_core (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .cmd_req_i         (cmd_req),
    .cmd_word_i        (cmd_word),
    .cmd_par_i         (cmd_par),
    .cmd_ack_o         (m_cmd_ack),
    .bus_req_o         (m_bus_req),
    .bus_we_o          (m_bus_we),
    .bus_addr_o        (m_bus_addr),
    .bus_wdata_o       (m_bus_wdata),
    .bus_ack_i         (bus_ack),
    .bus_rdata_i       (bus_rdata),
    .bus_err_i         (bus_err),
    .acc_o             (m_acc),
    .alert_minor_o     (),
    .alert_major_bus_o ()
  );

  core_lockstep #(
    .LockstepOffset (LockstepOffset)
  ) dut0 (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .cmd_req_i              (cmd_req),
    .cmd_word_i             (cmd_word),
    .cmd_par_i              (cmd_par),
    .bus_ack_i              (bus_ack),
    .bus_rdata_i            (bus_rdata),
    .bus_err_i              (bus_err),
    .cmd_ack_main_i         (m_cmd_ack),
    .bus_req_main_i         (m_bus_req),
    .bus_we_main_i          (m_bus_we),
    .bus_addr_main_i        (m_bus_addr),
    .bus_wdata_main_i       (m_bus_wdata ^ corrupt_mask),
    .acc_main_i             (m_acc),
    .alert_minor_o          (alert_minor),
    .alert_major_internal_o (alert_major_internal),
    .alert_major_bus_o      (alert_major_bus)
  );

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("TEST FAIL");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  // Every address bit takes part in the read data pattern
  function automatic logic [lockstep_pkg::DataWidth-1:0] fill_word(
    input logic [lockstep_pkg::AddrWidth-1:0] addr);
    return {addr[3:0], addr} ^ 16'h3c5a;
  endfunction

  `include "tb_lockstep_tasks.svh"

  ////////////////////////////////////////////////////////////
  // Memory model acks after ack_delay cycles of bus_req
  ////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    if (!bus_ack && m_bus_req) begin
      if (wait_cnt == ack_delay) begin
        bus_ack   <= 1'b1;
        bus_rdata <= fill_word(m_bus_addr);
        bus_err   <= err_next;
        wait_cnt  <= 0;
        if (m_bus_we) begin
          wr_data <= m_bus_wdata;
        end
      end else begin
        wait_cnt <= wait_cnt + 1;
      end
    end else if (bus_ack && !m_bus_req) begin
      bus_ack <= 1'b0;
      bus_err <= 1'b0;
    end
  end

  // Alerts stay quiet outside the windows that expect a pulse
  always @(negedge clk_i) begin
    if (mon_en && !window_open) begin
      check_alerts(1'b0, 1'b0, 1'b0);
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      fail_run("Timeout: the test sequence did not finish within the cycle limit");
    end
  end

  initial begin
    void'($urandom(Seed));
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    cmd_req      = 1'b0;
    cmd_word     = '0;
    cmd_par      = 1'b0;
    bus_ack      = 1'b0;
    bus_rdata    = '0;
    bus_err      = 1'b0;
    corrupt_mask = 16'h8001;
    ack_delay    = 0;
    wait_cnt     = 0;
    err_next     = 1'b0;
    wr_data      = '0;
    exp_acc      = '0;
    mon_en       = 1'b0;
    window_open  = 1'b0;
    cycle_cnt    = 0;

    quiet_through_reset();
    good_command_sequence();
    corrupted_store();
    bad_parity_command();
    load_with_bus_error();
    repeat (10) @(posedge clk_i);

    $display("TEST PASS");
    $finish;
  end

endmodule

// File: core_lockstep.sv
////////////////////////////////////////////////////////////
// Dual-core lockstep checker
// Runs a shadow accumulator core on the main core's inputs
// delayed by LockstepOffset cycles and compares its outputs
// with the main core's, delayed to match
////////////////////////////////////////////////////////////

module core_lockstep #(
  parameter int unsigned LockstepOffset = 2
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,

  // Host and memory side, as seen by the main core
  input  logic                               cmd_req_i,
  input  lockstep_pkg::cmd_word_u            cmd_word_i,
  input  logic                               cmd_par_i,
  input  logic                               bus_ack_i,
  input  logic [lockstep_pkg::DataWidth-1:0] bus_rdata_i,
  input  logic                               bus_err_i,

  // Main core outputs
  input  logic                               cmd_ack_main_i,
  input  logic                               bus_req_main_i,
  input  logic                               bus_we_main_i,
  input  logic [lockstep_pkg::AddrWidth-1:0] bus_addr_main_i,
  input  logic [lockstep_pkg::DataWidth-1:0] bus_wdata_main_i,
  input  logic [lockstep_pkg::DataWidth-1:0] acc_main_i,

  output logic                               alert_minor_o,
  output logic                               alert_major_internal_o,
  output logic                               alert_major_bus_o
);

  // Main outputs wait one more cycle for the shadow output register
  localparam int unsigned OutputsOffset = LockstepOffset + 1;

  logic                                  shadow_rst_n;
  lockstep_pkg::mubi_t                   cmp_en;

  logic [lockstep_pkg::CoreInWidth-1:0]  in_bundle, in_bundle_dly;
  logic [lockstep_pkg::CoreOutWidth-1:0] main_out, main_out_dly;
  logic [lockstep_pkg::CoreOutWidth-1:0] shadow_out;

  logic                                  sh_cmd_req;
  lockstep_pkg::cmd_word_u               sh_cmd_word;
  logic                                  sh_cmd_par;
  logic                                  sh_bus_ack;
  logic [lockstep_pkg::DataWidth-1:0]    sh_bus_rdata;
  logic                                  sh_bus_err;

  logic                                  sh_cmd_ack;
  logic                                  sh_bus_req;
  logic                                  sh_bus_we;
  logic [lockstep_pkg::AddrWidth-1:0]    sh_bus_addr;
  logic [lockstep_pkg::DataWidth-1:0]    sh_bus_wdata;
  logic [lockstep_pkg::DataWidth-1:0]    sh_acc;
  logic                                  sh_alert_minor;
  logic                                  sh_alert_major_bus;

  lockstep_rst_seq #(
    .LockstepOffset (LockstepOffset)
  ) u_rst_seq (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .shadow_rst_no (shadow_rst_n),
    .cmp_en_o      (cmp_en)
  );

  ////////////////////////////////////////////////////////////
  // Input delay to the shadow core
  ////////////////////////////////////////////////////////////

  assign in_bundle = {cmd_req_i, cmd_word_i, cmd_par_i, bus_ack_i, bus_rdata_i, bus_err_i};

  lockstep_delay #(
    .Width (lockstep_pkg::CoreInWidth),
    .Depth (LockstepOffset)
  ) u_in_dly (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .data_i (in_bundle),
    .data_o (in_bundle_dly)
  );

  assign {sh_cmd_req, sh_cmd_word, sh_cmd_par, sh_bus_ack, sh_bus_rdata, sh_bus_err} =
    in_bundle_dly;

  acc_core u_shadow_core (
    .clk_i             (clk_i),
    .rst_ni            (shadow_rst_n),
    .cmd_req_i         (sh_cmd_req),
    .cmd_word_i        (sh_cmd_word),
    .cmd_par_i         (sh_cmd_par),
    .cmd_ack_o         (sh_cmd_ack),
    .bus_req_o         (sh_bus_req),
    .bus_we_o          (sh_bus_we),
    .bus_addr_o        (sh_bus_addr),
    .bus_wdata_o       (sh_bus_wdata),
    .bus_ack_i         (sh_bus_ack),
    .bus_rdata_i       (sh_bus_rdata),
    .bus_err_i         (sh_bus_err),
    .acc_o             (sh_acc),
    .alert_minor_o     (sh_alert_minor),
    .alert_major_bus_o (sh_alert_major_bus)
  );

  ////////////////////////////////////////////////////////////
  // Output delay and compare
  ////////////////////////////////////////////////////////////

  assign main_out = {cmd_ack_main_i, bus_req_main_i, bus_we_main_i,
                     bus_addr_main_i, bus_wdata_main_i, acc_main_i};

  assign shadow_out = {sh_cmd_ack, sh_bus_req, sh_bus_we, sh_bus_addr, sh_bus_wdata, sh_acc};

  lockstep_delay #(
    .Width (lockstep_pkg::CoreOutWidth),
    .Depth (OutputsOffset)
  ) u_out_dly (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .data_i (main_out),
    .data_o (main_out_dly)
  );

  lockstep_compare u_compare (
    .clk_i                    (clk_i),
    .rst_ni                   (rst_ni),
    .cmp_en_i                 (cmp_en),
    .shadow_out_i             (shadow_out),
    .main_out_dly_i           (main_out_dly),
    .shadow_alert_minor_i     (sh_alert_minor),
    .shadow_alert_major_bus_i (sh_alert_major_bus),
    .alert_minor_o            (alert_minor_o),
    .alert_major_internal_o   (alert_major_internal_o),
    .alert_major_bus_o        (alert_major_bus_o)
  );

endmodule

// File: lockstep_compare.sv
////////////////////////////////////////////////////////////
// Lockstep comparator
// Registers the shadow core outputs, compares them with
// the delayed main core outputs and forms the alerts
////////////////////////////////////////////////////////////

module lockstep_compare (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  lockstep_pkg::mubi_t                   cmp_en_i,
  input  logic [lockstep_pkg::CoreOutWidth-1:0] shadow_out_i,
  input  logic [lockstep_pkg::CoreOutWidth-1:0] main_out_dly_i,
  input  logic                                  shadow_alert_minor_i,
  input  logic                                  shadow_alert_major_bus_i,
  output logic                                  alert_minor_o,
  output logic                                  alert_major_internal_o,
  output logic                                  alert_major_bus_o
);

  logic [lockstep_pkg::CoreOutWidth-1:0] shadow_out_q;
  logic                                  cmp_active;
  logic                                  outputs_mismatch;

  // Extra cycle here lines the shadow up with the main delay line
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      shadow_out_q <= '0;
    end else begin
      shadow_out_q <= shadow_out_i;
    end
  end

  // Only a clean Off code disables the check
  assign cmp_active       = (cmp_en_i != lockstep_pkg::MubiOff);
  assign outputs_mismatch = cmp_active && (shadow_out_q != main_out_dly_i);

  assign alert_major_internal_o = outputs_mismatch;

  // Shadow alerts go out as they are
  assign alert_minor_o     = shadow_alert_minor_i;
  assign alert_major_bus_o = shadow_alert_major_bus_i;

endmodule

// File: lockstep_delay.sv
////////////////////////////////////////////////////////////
// Lockstep delay line
// Shift register of Depth stages that delays a flat bundle
// of Width bits, cleared to zero on reset
////////////////////////////////////////////////////////////

module lockstep_delay #(
  parameter int unsigned Width = 8,
  parameter int unsigned Depth = 2
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic [Width-1:0] data_i,
  output logic [Width-1:0] data_o
);

  logic [Depth-1:0][Width-1:0] stage_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stage_q <= '0;
    end else begin
      stage_q[0] <= data_i;
      for (int unsigned i = 1; i < Depth; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign data_o = stage_q[Depth-1];

  // Once the line has filled past reset, the output is the input Depth cycles back
  delay_match_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $past(rst_ni, Depth) |-> (data_o == $past(data_i, Depth)));

endmodule

// File: lockstep_rst_seq.sv
////////////////////////////////////////////////////////////
// Lockstep reset sequencer
// Holds the shadow core in reset for LockstepOffset cycles
// after system reset, then enables output comparison one
// cycle after the shadow reset is released
////////////////////////////////////////////////////////////

module lockstep_rst_seq #(
  parameter int unsigned LockstepOffset = 2
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  output logic                shadow_rst_no,
  output lockstep_pkg::mubi_t cmp_en_o
);

  localparam int unsigned CntWidth = (LockstepOffset > 1) ? $clog2(LockstepOffset) : 1;

  logic [CntWidth-1:0] cnt_q;
  logic                cnt_done;
  lockstep_pkg::mubi_t rst_set_d, rst_set_q;
  lockstep_pkg::mubi_t cmp_en_q;

  assign cnt_done = (cnt_q == CntWidth'(LockstepOffset - 1));

  // Saturates at LockstepOffset-1
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (!cnt_done) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign rst_set_d = cnt_done ? lockstep_pkg::MubiOn : lockstep_pkg::MubiOff;

  // Release flag, then the compare enable one cycle behind it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rst_set_q <= lockstep_pkg::MubiOff;
      cmp_en_q  <= lockstep_pkg::MubiOff;
    end else begin
      rst_set_q <= rst_set_d;
      cmp_en_q  <= rst_set_q;
    end
  end

  // Shadow stays in reset on any code other than On
  assign shadow_rst_no = (rst_set_q == lockstep_pkg::MubiOn);
  assign cmp_en_o      = cmp_en_q;

  // Comparison only runs once the shadow has been out of reset a full cycle
  cmp_after_release_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (cmp_en_o == lockstep_pkg::MubiOn) |-> (shadow_rst_no && $past(shadow_rst_no)));

endmodule

// File: acc_core.sv
////////////////////////////////////////////////////////////
// Accumulator core
// Takes commands over a four-phase req/ack handshake and
// runs ADD/XOR immediate, LOAD and STORE on a 16-bit
// accumulator, with its own four-phase bus port. Flags bad
// command parity and bus errors as one-cycle alerts
////////////////////////////////////////////////////////////

module acc_core (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                cmd_req_i,
  input  lockstep_pkg::cmd_word_u             cmd_word_i,
  input  logic                                cmd_par_i,
  output logic                                cmd_ack_o,
  output logic                                bus_req_o,
  output logic                                bus_we_o,
  output logic [lockstep_pkg::AddrWidth-1:0]  bus_addr_o,
  output logic [lockstep_pkg::DataWidth-1:0]  bus_wdata_o,
  input  logic                                bus_ack_i,
  input  logic [lockstep_pkg::DataWidth-1:0]  bus_rdata_i,
  input  logic                                bus_err_i,
  output logic [lockstep_pkg::DataWidth-1:0]  acc_o,
  output logic                                alert_minor_o,
  output logic                                alert_major_bus_o
);

  localparam logic [1:0] StIdle   = 2'd0;
  localparam logic [1:0] StBusReq = 2'd1;
  localparam logic [1:0] StBusRel = 2'd2;
  localparam logic [1:0] StAck    = 2'd3;

  logic [1:0]                         state_q;
  logic [lockstep_pkg::DataWidth-1:0] acc_q;
  logic [lockstep_pkg::DataWidth-1:0] imm_ext;
  logic [lockstep_pkg::DataWidth-1:0] alu_result;
  logic                               cmd_ack_q;
  logic                               bus_req_q;
  logic                               bus_we_q;
  logic [lockstep_pkg::AddrWidth-1:0] bus_addr_q;
  logic [lockstep_pkg::DataWidth-1:0] bus_wdata_q;
  logic                               alert_minor_q;
  logic                               alert_major_bus_q;
  logic                               parity_err;
  logic                               is_mem_op;

  // Word plus parity bit must be even
  assign parity_err = ^{cmd_word_i, cmd_par_i};

  assign is_mem_op = (cmd_word_i.mem.op == lockstep_pkg::OpLoad) ||
                     (cmd_word_i.mem.op == lockstep_pkg::OpStore);

  assign imm_ext = {{(lockstep_pkg::DataWidth - lockstep_pkg::ImmWidth){1'b0}},
                    cmd_word_i.imm.imm};

  // Immediate ops, unknown opcodes leave acc alone
  always_comb begin
    alu_result = acc_q;
    case (cmd_word_i.imm.op)
      lockstep_pkg::OpAdd: alu_result = acc_q + imm_ext;
      lockstep_pkg::OpXor: alu_result = acc_q ^ imm_ext;
      default:             alu_result = acc_q;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Command and bus FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q           <= StIdle;
      acc_q             <= '0;
      cmd_ack_q         <= 1'b0;
      bus_req_q         <= 1'b0;
      bus_we_q          <= 1'b0;
      bus_addr_q        <= '0;
      bus_wdata_q       <= '0;
      alert_minor_q     <= 1'b0;
      alert_major_bus_q <= 1'b0;
    end else begin
      alert_minor_q     <= 1'b0;
      alert_major_bus_q <= 1'b0;
      case (state_q)
        StIdle: begin
          if (cmd_req_i) begin
            if (parity_err) begin
              // Acked like ADD but acc is kept
              alert_minor_q <= 1'b1;
              cmd_ack_q     <= 1'b1;
              state_q       <= StAck;
            end else if (is_mem_op) begin
              bus_req_q   <= 1'b1;
              bus_we_q    <= (cmd_word_i.mem.op == lockstep_pkg::OpStore);
              bus_addr_q  <= cmd_word_i.mem.addr;
              bus_wdata_q <= acc_q;
              state_q     <= StBusReq;
            end else begin
              acc_q     <= alu_result;
              cmd_ack_q <= 1'b1;
              state_q   <= StAck;
            end
          end
        end
        StBusReq: begin
          // Payload stays put until memory answers
          if (bus_ack_i) begin
            bus_req_q <= 1'b0;
            if (bus_err_i) begin
              alert_major_bus_q <= 1'b1;
            end else if (!bus_we_q) begin
              acc_q <= acc_q + bus_rdata_i;
            end
            state_q <= StBusRel;
          end
        end
        StBusRel: begin
          if (!bus_ack_i) begin
            cmd_ack_q <= 1'b1;
            state_q   <= StAck;
          end
        end
        StAck: begin
          if (!cmd_req_i) begin
            cmd_ack_q <= 1'b0;
            state_q   <= StIdle;
          end
        end
        default: state_q <= StIdle;
      endcase
    end
  end

  assign cmd_ack_o         = cmd_ack_q;
  assign bus_req_o         = bus_req_q;
  assign bus_we_o          = bus_we_q;
  assign bus_addr_o        = bus_addr_q;
  assign bus_wdata_o       = bus_wdata_q;
  assign acc_o             = acc_q;
  assign alert_minor_o     = alert_minor_q;
  assign alert_major_bus_o = alert_major_bus_q;

  // A bus request is only withdrawn after memory has acked it
  bus_req_until_ack_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(bus_req_o) |-> $past(bus_ack_i));

endmodule

// File: lockstep_pkg.sv
////////////////////////////////////////////////////////////
// Lockstep package
// Widths, the command word with its two decode views, the
// accumulator core opcodes and the multi-bit enable codes
////////////////////////////////////////////////////////////

package lockstep_pkg;

  parameter int unsigned DataWidth   = 16;
  parameter int unsigned AddrWidth   = 12;
  parameter int unsigned CmdWidth    = 16;
  parameter int unsigned OpcodeWidth = 4;
  parameter int unsigned ImmWidth    = CmdWidth - OpcodeWidth;

  // Flat bundles carried by the delay lines
  // Inputs are cmd_req, cmd_word, cmd_par, bus_ack, bus_rdata and bus_err
  parameter int unsigned CoreInWidth  = 4 + CmdWidth + DataWidth;
  // Outputs are cmd_ack, bus_req, bus_we, bus_addr, bus_wdata and acc
  parameter int unsigned CoreOutWidth = 3 + AddrWidth + 2 * DataWidth;

  // Any opcode not listed is a no-op that still gets an ack
  typedef enum logic [OpcodeWidth-1:0] {
    OpAdd   = 4'h1,
    OpXor   = 4'h2,
    OpLoad  = 4'h3,
    OpStore = 4'h4
  } opcode_e;

  // One command word, read as immediate (ADD, XOR) or as address (LOAD, STORE)
  typedef union packed {
    struct packed {
      opcode_e             op;
      logic [ImmWidth-1:0] imm;
    } imm;
    struct packed {
      opcode_e              op;
      logic [AddrWidth-1:0] addr;
    } mem;
  } cmd_word_u;

  // Multi-bit enable, anything but the two codes counts as invalid
  typedef logic [3:0] mubi_t;

  parameter mubi_t MubiOn  = 4'b0101;
  parameter mubi_t MubiOff = 4'b1010;

endpackage
